// ==== design/dlx_ex_pkg.sv ====
package dlx_ex_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int OFF16_W    = 16;
    localparam int OFF26_W    = 26;
    localparam int SHAMT_W    = 5;

    typedef enum logic [0:3] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9,
        ALU_SEQ  = 4'd10,
        ALU_SNE  = 4'd11
    } alu_op_e;

    typedef enum logic [0:1] {
        MEM_BYTE = 2'd0,
        MEM_HALF = 2'd1,
        MEM_WORD = 2'd2
    } mem_size_e;

    // Carried untouched to the memory and writeback stages
    typedef struct packed {
        logic      pc_to_reg;   // Link register receives next_pc
        logic      reg_write;
        logic      mem_to_reg;
        logic      mem_write;
        logic      load_sign;
        mem_size_e dsize;
    } mem_ctrl_t;

    typedef struct packed {
        mem_ctrl_t mem;
        logic      reg_to_pc;   // Jump target comes from op_a
        logic      jump;
        logic      branch;
        logic      branch_zero; // Branch taken when op_a is zero
        logic      rtype;       // Operand B is rt_val, not the immediate
        logic      mul;
        alu_op_e   alu_op;
    } ctrl_t;

    typedef struct packed {
        logic [0:XLEN-1]       next_pc;
        logic [0:XLEN-1]       rs_val;
        logic [0:XLEN-1]       rt_val;
        logic [0:OFF16_W-1]    offset16;
        logic [0:OFF26_W-1]    offset26;
        logic [0:REG_ADDR_W-1] dest_reg;
        ctrl_t                 ctrl;
    } dec_in_t;

    typedef struct packed {
        logic [0:XLEN-1]       next_pc;
        logic [0:XLEN-1]       op_a;
        logic [0:XLEN-1]       op_b;
        logic [0:XLEN-1]       store_data;
        logic [0:XLEN-1]       imm;         // Offset added to next_pc for the leap
        logic [0:REG_ADDR_W-1] dest_reg;
        ctrl_t                 ctrl;
    } id_ex_t;

    typedef struct packed {
        logic [0:XLEN-1]       next_pc;
        logic [0:XLEN-1]       alu_result;
        logic [0:XLEN-1]       store_data;
        logic [0:XLEN-1]       leap_addr;
        logic                  leap;
        logic                  overflow;
        logic [0:REG_ADDR_W-1] dest_reg;
        mem_ctrl_t             mem;
    } ex_mem_t;

endpackage

// ==== design/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  logic [0:dlx_ex_pkg::XLEN-1] a,
    input  logic [0:dlx_ex_pkg::XLEN-1] b,
    input  dlx_ex_pkg::alu_op_e          op,
    output logic [0:dlx_ex_pkg::XLEN-1] result,
    output logic                         zero,
    output logic                         overflow
);
    import dlx_ex_pkg::*;

    logic [0:SHAMT_W-1] shamt;
    logic [0:XLEN-1]    sum;
    logic [0:XLEN-1]    diff;
    logic               lt_signed;
    logic               lt_unsigned;
    logic               add_ov;
    logic               sub_ov;

    assign shamt = b[XLEN-SHAMT_W:XLEN-1]; // Bit 0 is the MSB, so the low bits sit at the end
    assign sum   = a + b;
    assign diff  = a - b;

    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;
    assign zero        = (a == b);

    // Signed overflow shows as a sign bit that disagrees with the operands
    assign add_ov = (a[0] == b[0]) && (sum[0] != a[0]);
    assign sub_ov = (a[0] != b[0]) && (diff[0] != a[0]);

    always_comb begin
        result   = '0;
        overflow = 1'b0;
        case (op)
            ALU_ADD: begin
                result   = sum;
                overflow = add_ov;
            end
            ALU_SUB: begin
                result   = diff;
                overflow = sub_ov;
            end
            ALU_AND: begin
                result = a & b;
            end
            ALU_OR: begin
                result = a | b;
            end
            ALU_XOR: begin
                result = a ^ b;
            end
            ALU_SLL: begin
                result = a << shamt;
            end
            ALU_SRL: begin
                result = a >> shamt;
            end
            ALU_SRA: begin
                result = $signed(a) >>> shamt;
            end
            ALU_SLT: begin
                result = {{(XLEN-1){1'b0}}, lt_signed};
            end
            ALU_SLTU: begin
                result = {{(XLEN-1){1'b0}}, lt_unsigned};
            end
            ALU_SEQ: begin
                result = {{(XLEN-1){1'b0}}, zero};
            end
            ALU_SNE: begin
                result = {{(XLEN-1){1'b0}}, !zero};
            end
            default: begin
                result = '0; // Unused codes give zero
            end
        endcase
    end

endmodule

// ==== design/branch_unit.sv ====
`timescale 1ns/1ps

module branch_unit (
    input  logic                         valid,
    input  logic [0:dlx_ex_pkg::XLEN-1] op_a,
    input  logic [0:dlx_ex_pkg::XLEN-1] next_pc,
    input  logic [0:dlx_ex_pkg::XLEN-1] imm,
    input  logic                         jump,
    input  logic                         branch,
    input  logic                         branch_zero,
    input  logic                         reg_to_pc,
    output logic                         leap,
    output logic [0:dlx_ex_pkg::XLEN-1] leap_addr
);
    import dlx_ex_pkg::*;

    logic            op_a_zero;
    logic            cond_holds;
    logic [0:XLEN-1] rel_target;

    assign op_a_zero = (op_a == '0);

    // BEQZ wants a zero register, BNEZ a nonzero one
    assign cond_holds = (op_a_zero == branch_zero);

    assign leap = valid && (jump || (branch && cond_holds));

    assign rel_target = next_pc + imm; // PC relative target for branches and J/JAL

    always_comb begin
        if (reg_to_pc) begin
            leap_addr = op_a; // JR and JALR
        end else begin
            leap_addr = rel_target;
        end
    end

endmodule

// ==== design/operand_stage.sv ====
`timescale 1ns/1ps

module operand_stage (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    input  dlx_ex_pkg::dec_in_t   in,
    input  logic                  flush,
    output logic                  id_valid,
    output dlx_ex_pkg::id_ex_t    id
);
    import dlx_ex_pkg::*;

    logic [0:XLEN-1] imm16_ext;
    logic [0:XLEN-1] imm26_ext;
    id_ex_t          id_next;

    // Both offsets are signed
    assign imm16_ext = {{(XLEN-OFF16_W){in.offset16[0]}}, in.offset16};
    assign imm26_ext = {{(XLEN-OFF26_W){in.offset26[0]}}, in.offset26};

    always_comb begin
        id_next.next_pc    = in.next_pc;
        id_next.op_a       = in.rs_val;
        id_next.op_b       = in.ctrl.rtype ? in.rt_val : imm16_ext;
        id_next.store_data = in.rt_val;     // Store value always comes from rt
        id_next.imm        = in.ctrl.branch ? imm16_ext : imm26_ext;
        id_next.dest_reg   = in.dest_reg;
        id_next.ctrl       = in.ctrl;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            id_valid <= 1'b0;
        end else begin
            id_valid <= in_valid && !flush; // Kill the slot behind a taken leap
        end
    end

    always_ff @(posedge clk) begin
        id <= id_next;
    end

endmodule

// ==== design/execute.sv ====
`timescale 1ns/1ps

module execute (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  id_valid,
    input  dlx_ex_pkg::id_ex_t    id,
    output logic                  leap_now,
    output logic                  out_valid,
    output dlx_ex_pkg::ex_mem_t   out
);
    import dlx_ex_pkg::*;

    logic [0:XLEN-1] alu_result;
    logic [0:XLEN-1] mul_result;
    logic [0:XLEN-1] leap_addr;
    logic            alu_overflow;
    ex_mem_t         ex_next;

    alu u_alu (
        .a        (id.op_a),
        .b        (id.op_b),
        .op       (id.ctrl.alu_op),
        .result   (alu_result),
        .zero     (),
        .overflow (alu_overflow)
    );

    branch_unit u_branch (
        .valid       (id_valid),
        .op_a        (id.op_a),
        .next_pc     (id.next_pc),
        .imm         (id.imm),
        .jump        (id.ctrl.jump),
        .branch      (id.ctrl.branch),
        .branch_zero (id.ctrl.branch_zero),
        .reg_to_pc   (id.ctrl.reg_to_pc),
        .leap        (leap_now),
        .leap_addr   (leap_addr)
    );

    assign mul_result = id.op_a * id.op_b; // Keeps the low word of the product

    always_comb begin
        ex_next.next_pc    = id.next_pc;
        ex_next.alu_result = id.ctrl.mul ? mul_result : alu_result;
        ex_next.store_data = id.store_data;
        ex_next.leap_addr  = leap_addr;
        ex_next.leap       = leap_now;
        ex_next.overflow   = alu_overflow;
        ex_next.dest_reg   = id.dest_reg;
        ex_next.mem        = id.ctrl.mem;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= id_valid;
        end
    end

    // EX/MEM record
    always_ff @(posedge clk) begin
        out <= ex_next;
    end

endmodule

// ==== design/ex_pipe.sv ====
`timescale 1ns/1ps

module ex_pipe (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    input  dlx_ex_pkg::dec_in_t   in,
    output logic                  out_valid,
    output dlx_ex_pkg::ex_mem_t   out
);
    import dlx_ex_pkg::*;

    logic   id_valid;
    id_ex_t id;
    logic   leap_now;

    operand_stage u_operand (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in       (in),
        .flush    (leap_now), // Squash the instruction right behind a taken leap
        .id_valid (id_valid),
        .id       (id)
    );

    execute u_execute (
        .clk       (clk),
        .rst       (rst),
        .id_valid  (id_valid),
        .id        (id),
        .leap_now  (leap_now),
        .out_valid (out_valid),
        .out       (out)
    );

endmodule

// ==== tests/ex_pipe_asserts.sv ====
`timescale 1ns/1ps

module ex_pipe_asserts (
    input logic                clk,
    input logic                rst,
    input logic                out_valid,
    input dlx_ex_pkg::ex_mem_t out
);

    // Sampled on the falling edge so the reset value has settled
    a_idle_in_reset: assert property (@(negedge clk) rst |-> !out_valid)
        else $error("out_valid is high while rst is asserted");

    // The instruction right behind a taken leap is squashed in the operand stage
    a_bubble_after_leap: assert property (@(posedge clk) disable iff (rst)
        out_valid && out.leap |=> !out_valid)
        else $error("An instruction behind a taken leap reached the output");

    a_known_output: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> !$isunknown(out))
        else $error("EX/MEM record has unknown bits while out_valid is high");

endmodule

bind ex_pipe ex_pipe_asserts u_asserts (
    .clk       (clk),
    .rst       (rst),
    .out_valid (out_valid),
    .out       (out)
);

// ==== tests/ex_pipe_tb.sv ====
`timescale 1ns/1ps

module ex_pipe_tb;
    import dlx_ex_pkg::*;

    localparam int          CLK_PERIOD   = 100;
    localparam int          RESET_CYCLES = 4;
    localparam int          N_DIRECTED   = 34;
    localparam int          N_RANDOM     = 200;
    localparam int          MAX_GAP      = 2;
    localparam int          MEM_CTRL_W   = $bits(mem_ctrl_t);
    localparam int          CTRL_W       = $bits(ctrl_t);
    localparam logic [31:0] BASE_PC      = 32'h0000_1000;

    // Leap kinds as {jump, branch, branch_zero, reg_to_pc}
    localparam logic [3:0] BEQZ = 4'b0110;
    localparam logic [3:0] BNEZ = 4'b0100;
    localparam logic [3:0] JMP  = 4'b1000;
    localparam logic [3:0] JREG = 4'b1001;

    typedef struct {
        logic    valid;
        dec_in_t in;
        ex_mem_t exp;
    } vec_t;

    typedef struct {
        ex_mem_t rec;
        int      due;   // Falling edge at which the record must be on out
    } sb_entry_t;

    logic    clk;
    logic    rst;
    logic    in_valid;
    dec_in_t in;
    logic    out_valid;
    ex_mem_t out;

    vec_t      tab[$];
    sb_entry_t exp_q[$];
    int        edge_count = 0;
    int        squashed   = 0;
    logic      prev_leap  = 1'b0;
    integer    seed;

    ex_pipe UUT (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in        (in),
        .out_valid (out_valid),
        .out       (out)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            fail_run($sformatf("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_record(input ex_mem_t e);
        check_field("out.next_pc", out.next_pc, e.next_pc);
        check_field("out.alu_result", out.alu_result, e.alu_result);
        check_field("out.store_data", out.store_data, e.store_data);
        check_field("out.leap_addr", out.leap_addr, e.leap_addr);
        check_field("out.leap", out.leap, e.leap);
        check_field("out.overflow", out.overflow, e.overflow);
        check_field("out.dest_reg", out.dest_reg, e.dest_reg);
        check_field("out.mem", out.mem, e.mem);
    endtask

    function automatic logic [31:0] sext16(input logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    function automatic logic [31:0] sext26(input logic [25:0] v);
        return {{6{v[25]}}, v};
    endfunction

    function automatic ex_mem_t model_ex(input dec_in_t d);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [32:0] wide;
        logic [63:0] prod;
        logic [31:0] res;
        logic [4:0]  sh;
        logic        ov;
        ex_mem_t     e;
        a    = d.rs_val;
        b    = d.ctrl.rtype ? d.rt_val : sext16(d.offset16);
        imm  = d.ctrl.branch ? sext16(d.offset16) : sext26(d.offset26);
        sh   = b[4:0];
        ov   = 1'b0;
        wide = '0;
        case (d.ctrl.alu_op)
            ALU_ADD:  wide = {a[31], a} + {b[31], b};
            ALU_SUB:  wide = {a[31], a} - {b[31], b};
            default:  wide = '0;
        endcase
        case (d.ctrl.alu_op)
            ALU_ADD, ALU_SUB: begin
                res = wide[31:0];
                ov  = wide[32] != wide[31]; // Sign lost in the 33 bit result
            end
            ALU_AND:  res = a & b;
            ALU_OR:   res = a | b;
            ALU_XOR:  res = a ^ b;
            ALU_SLL:  res = a << sh;
            ALU_SRL:  res = a >> sh;
            ALU_SRA:  res = (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
            ALU_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLTU: res = (a < b) ? 32'd1 : 32'd0;
            ALU_SEQ:  res = (a == b) ? 32'd1 : 32'd0;
            ALU_SNE:  res = (a != b) ? 32'd1 : 32'd0;
            default:  res = '0;
        endcase
        if (d.ctrl.mul) begin
            prod = {32'h0, a} * {32'h0, b};
            res  = prod[31:0];
        end
        e.next_pc    = d.next_pc;
        e.alu_result = res;
        e.store_data = d.rt_val;
        e.leap       = d.ctrl.jump || (d.ctrl.branch &&
                       ((a == 0 && d.ctrl.branch_zero) || (a != 0 && !d.ctrl.branch_zero)));
        e.leap_addr  = d.ctrl.reg_to_pc ? a : d.next_pc + imm;
        e.overflow   = ov;
        e.dest_reg   = d.dest_reg;
        e.mem        = d.ctrl.mem;
        return e;
    endfunction

    function automatic dec_in_t base_instr();
        dec_in_t d;
        d          = '0;
        d.next_pc  = BASE_PC;
        d.rt_val   = 32'h5a5a_0000 + tab.size();
        d.dest_reg = 5'(tab.size());
        d.ctrl.mem = mem_ctrl_t'(MEM_CTRL_W'(tab.size() * 37)); // Varied pattern for the pass-through check
        return d;
    endfunction

    task automatic add_vec(input logic valid, input dec_in_t d, input logic [31:0] res,
                           input logic leap, input logic [31:0] addr, input logic ov);
        vec_t v;
        v.valid          = valid;
        v.in             = d;
        v.exp.next_pc    = d.next_pc;
        v.exp.alu_result = res;
        v.exp.store_data = d.rt_val;
        v.exp.leap_addr  = addr;
        v.exp.leap       = leap;
        v.exp.overflow   = ov;
        v.exp.dest_reg   = d.dest_reg;
        v.exp.mem        = d.ctrl.mem;
        tab.push_back(v);
    endtask

    task automatic add_alu(input alu_op_e op, input logic rtype, input logic mul,
                           input logic [31:0] rs, input logic [31:0] opb,
                           input logic [31:0] res, input logic ov);
        dec_in_t d;
        d             = base_instr();
        d.rs_val      = rs;
        d.ctrl.alu_op = op;
        d.ctrl.rtype  = rtype;
        d.ctrl.mul    = mul;
        if (rtype) begin
            d.rt_val = opb;
        end else begin
            d.offset16 = opb[15:0];
        end
        add_vec(1'b1, d, res, 1'b0, BASE_PC, ov); // Zero offset26 leaves the target at next_pc
    endtask

    // ADD with rt at zero makes alu_result equal to rs
    task automatic add_leap(input logic [3:0] kind, input logic [31:0] rs,
                            input logic [15:0] off16, input logic [25:0] off26,
                            input logic leap, input logic [31:0] addr);
        dec_in_t d;
        d                = base_instr();
        d.rs_val         = rs;
        d.rt_val         = '0;
        d.offset16       = off16;
        d.offset26       = off26;
        d.ctrl.rtype     = 1'b1;
        d.ctrl.alu_op    = ALU_ADD;
        d.ctrl.jump      = kind[3];
        d.ctrl.branch    = kind[2];
        d.ctrl.branch_zero = kind[1];
        d.ctrl.reg_to_pc = kind[0];
        add_vec(1'b1, d, rs, leap, addr, 1'b0);
    endtask

    task automatic add_bubble();
        add_vec(1'b0, base_instr(), 32'h0, 1'b0, BASE_PC, 1'b0);
    endtask

    task automatic fill_table();
        add_alu(ALU_ADD, 1'b1, 1'b0, 32'h7fff_ffff, 32'h0000_0001, 32'h8000_0000, 1'b1);
        add_alu(ALU_ADD, 1'b1, 1'b0, 32'h0000_0005, 32'h0000_0003, 32'h0000_0008, 1'b0);
        add_alu(ALU_SUB, 1'b1, 1'b0, 32'h8000_0000, 32'h0000_0001, 32'h7fff_ffff, 1'b1);
        add_alu(ALU_SUB, 1'b1, 1'b0, 32'h0000_0005, 32'h0000_0007, 32'hffff_fffe, 1'b0);
        add_alu(ALU_AND, 1'b1, 1'b0, 32'hf0f0_1234, 32'h0ff0_ffff, 32'h00f0_1234, 1'b0);
        add_alu(ALU_OR,  1'b1, 1'b0, 32'hf0f0_0000, 32'h0000_1234, 32'hf0f0_1234, 1'b0);
        add_alu(ALU_XOR, 1'b1, 1'b0, 32'hffff_0000, 32'h0f0f_0f0f, 32'hf0f0_0f0f, 1'b0);
        add_alu(ALU_SLL, 1'b1, 1'b0, 32'h0000_0001, 32'h0000_0024, 32'h0000_0010, 1'b0);
        add_alu(ALU_SRL, 1'b1, 1'b0, 32'h8000_0000, 32'h0000_0021, 32'h4000_0000, 1'b0);
        add_alu(ALU_SRA, 1'b1, 1'b0, 32'h8000_0000, 32'h0000_0004, 32'hf800_0000, 1'b0);
        add_alu(ALU_SLT, 1'b1, 1'b0, 32'hffff_ffff, 32'h0000_0001, 32'h0000_0001, 1'b0);
        add_alu(ALU_SLTU, 1'b1, 1'b0, 32'hffff_ffff, 32'h0000_0001, 32'h0000_0000, 1'b0);
        add_alu(ALU_SEQ, 1'b1, 1'b0, 32'h0000_1234, 32'h0000_1234, 32'h0000_0001, 1'b0);
        add_alu(ALU_SNE, 1'b1, 1'b0, 32'h0000_1234, 32'h0000_1234, 32'h0000_0000, 1'b0);
        // Immediate forms with negative offsets
        add_alu(ALU_ADD, 1'b0, 1'b0, 32'h0000_0010, 32'h0000_fff0, 32'h0000_0000, 1'b0);
        add_alu(ALU_SLT, 1'b0, 1'b0, 32'hffff_fff0, 32'h0000_fff8, 32'h0000_0001, 1'b0);
        add_alu(ALU_SLTU, 1'b0, 1'b0, 32'h0000_0005, 32'h0000_ffff, 32'h0000_0001, 1'b0);
        add_alu(ALU_AND, 1'b0, 1'b0, 32'hffff_ffff, 32'h0000_8001, 32'hffff_8001, 1'b0);
        add_alu(ALU_AND, 1'b1, 1'b1, 32'h0000_0006, 32'hffff_fffd, 32'hffff_ffee, 1'b0);
        add_alu(ALU_AND, 1'b1, 1'b1, 32'h0001_2345, 32'h0001_0000, 32'h2345_0000, 1'b0);
        add_alu(ALU_AND, 1'b1, 1'b1, 32'hffff_ffff, 32'hffff_ffff, 32'h0000_0001, 1'b0);
        add_leap(BEQZ, 32'h0000_0000, 16'h0040, 26'h0, 1'b1, 32'h0000_1040);
        add_alu(ALU_ADD, 1'b1, 1'b0, 32'h0000_0001, 32'h0000_0001, 32'h0000_0002, 1'b0);
        add_alu(ALU_ADD, 1'b1, 1'b0, 32'h0000_0002, 32'h0000_0002, 32'h0000_0004, 1'b0);
        add_leap(BEQZ, 32'h0000_0005, 16'h0040, 26'h0, 1'b0, 32'h0000_1040);
        add_leap(BNEZ, 32'h0000_0005, 16'hfff0, 26'h0, 1'b1, 32'h0000_0ff0);
        add_bubble();
        add_alu(ALU_ADD, 1'b1, 1'b0, 32'h0000_0003, 32'h0000_0004, 32'h0000_0007, 1'b0);
        add_leap(BNEZ, 32'h0000_0000, 16'h0008, 26'h0, 1'b0, 32'h0000_1008);
        add_leap(JMP, 32'h0000_0abc, 16'h0, 26'h3ff_fff0, 1'b1, 32'h0000_0ff0);
        add_alu(ALU_ADD, 1'b1, 1'b0, 32'h0000_0001, 32'h0000_0001, 32'h0000_0002, 1'b0);
        add_leap(JREG, 32'h0000_2000, 16'h0, 26'h0, 1'b1, 32'h0000_2000);
        add_bubble();
        add_alu(ALU_ADD, 1'b1, 1'b0, 32'h0000_0006, 32'hffff_fffe, 32'h0000_0004, 1'b0);
    endtask

    function automatic dec_in_t random_instr();
        dec_in_t d;
        int      kind;
        d.next_pc     = $random(seed);
        d.rs_val      = $random(seed);
        d.rt_val      = $random(seed);
        d.offset16    = 16'($random(seed));
        d.offset26    = 26'($random(seed));
        d.dest_reg    = 5'($random(seed));
        d.ctrl        = ctrl_t'(CTRL_W'($random(seed)));
        d.ctrl.alu_op = alu_op_e'(4'({$random(seed)} % 12));
        kind          = {$random(seed)} % 8;
        d.ctrl.jump   = (kind == 0);
        d.ctrl.branch = (kind == 1);
        d.ctrl.mul    = (kind == 2);
        if (kind == 1 && ({$random(seed)} % 2) == 0) begin
            d.rs_val = '0; // Gives the zero test a fair share of hits
        end
        return d;
    endfunction

    task automatic drive(input logic valid, input dec_in_t d, input ex_mem_t e);
        sb_entry_t s;
        @(posedge clk);
        in_valid <= valid;
        in       <= d;
        if (valid && prev_leap) begin
            squashed  = squashed + 1;
            prev_leap = 1'b0;
        end else if (valid) begin
            s.rec     = e;
            s.due     = edge_count + 3;
            exp_q.push_back(s);
            prev_leap = e.leap;
        end else begin
            prev_leap = 1'b0;
        end
    endtask

    always @(negedge clk) begin
        edge_count = edge_count + 1;
        assert (!$isunknown(out_valid)) else fail_run("out_valid is unknown");
        if (out_valid) begin
            assert (exp_q.size() != 0 && exp_q[0].due == edge_count) else begin
                fail_run($sformatf("out_valid rose at %0t ns with no instruction due", $time));
            end
            check_record(exp_q[0].rec);
            void'(exp_q.pop_front());
        end else begin
            assert (exp_q.size() == 0 || exp_q[0].due != edge_count) else begin
                fail_run($sformatf("An expected result was missing at %0t ns", $time));
            end
        end
    end

    initial begin
        #((N_DIRECTED + N_RANDOM * (MAX_GAP + 1) + RESET_CYCLES + 20) * CLK_PERIOD);
        fail_run("Timeout: the run did not finish within the expected number of cycles");
    end

    initial begin
        dec_in_t d;
        int      gap;
        seed     = 32'h99b9_5a24;
        rst      = 1'b1;
        in_valid = 1'b0;
        in       = '0;
        d        = '0;
        fill_table();
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        foreach (tab[i]) begin
            drive(tab[i].valid, tab[i].in, tab[i].exp);
        end
        for (int i = 0; i < N_RANDOM; i++) begin
            d = random_instr();
            drive(1'b1, d, model_ex(d));
            gap = {$random(seed)} % (MAX_GAP + 1);
            repeat (gap) drive(1'b0, d, model_ex(d));
        end
        repeat (4) drive(1'b0, d, model_ex(d)); // Lets the last records drain
        $display("%0d instructions squashed behind taken leaps", squashed);
        if (exp_q.size() != 0) begin
            fail_run($sformatf("%0d expected results never reached the output", exp_q.size()));
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule

// ==== ex_pipe.f ====
design/dlx_ex_pkg.sv
design/alu.sv
design/branch_unit.sv
design/operand_stage.sv
design/execute.sv
design/ex_pipe.sv
tests/ex_pipe_asserts.sv
tests/ex_pipe_tb.sv

// ==== Bender.yml ====
package:
  name: ex_pipe

sources:
  - design/dlx_ex_pkg.sv
  - design/alu.sv
  - design/branch_unit.sv
  - design/operand_stage.sv
  - design/execute.sv
  - design/ex_pipe.sv
  - target: test
    files:
      - tests/ex_pipe_asserts.sv
      - tests/ex_pipe_tb.sv
